//--- serial_link.f
+incdir+.
serial_link_pkg.sv
serial_link_tx_path.sv
serial_link_rx_path.sv
serial_link_framer.sv
serial_link.sv
tb_serial_link.sv

//--- serial_link.sv
// Serial link top level
// Single channel link over a few lanes with credit flow control.
// Transmit path and receive path run side by side, the framer
// merges outgoing words and returned credits into frames
`timescale 1ns/1ps
`include "serial_link_config.svh"

module serial_link
  import serial_link_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  // User word input
  input  data_t data_in_i,
  input  logic  data_in_valid_i,
  output logic  data_in_ready_o,
  // User word output
  output data_t data_out_o,
  output logic  data_out_valid_o,
  input  logic  data_out_ready_i,
  // Serial lanes
  output lane_t ser_data_o,
  output logic  ser_valid_o,
  input  lane_t ser_data_i,
  input  logic  ser_valid_i
);

  data_t   tx_word;
  logic    tx_word_valid;
  logic    word_take;
  credit_t credit_pending;
  logic    credit_sent;
  credit_t credit_recv;
  logic    credit_recv_valid;

  //////////////////////////////////////////////////
  // Transmit side
  //////////////////////////////////////////////////

  serial_link_tx_path u_tx_path (
    .clk_i              ( clk_i             ),
    .rst_n_i            ( rst_n_i           ),
    .data_i             ( data_in_i         ),
    .valid_i            ( data_in_valid_i   ),
    .ready_o            ( data_in_ready_o   ),
    .credit_add_i       ( credit_recv       ),
    .credit_add_valid_i ( credit_recv_valid ),
    .word_o             ( tx_word           ),
    .word_valid_o       ( tx_word_valid     ),
    .word_take_i        ( word_take         )
  );

  serial_link_framer u_framer (
    .clk_i            ( clk_i          ),
    .rst_n_i          ( rst_n_i        ),
    .word_i           ( tx_word        ),
    .word_valid_i     ( tx_word_valid  ),
    .word_take_o      ( word_take      ),
    .credit_pending_i ( credit_pending ),
    .credit_sent_o    ( credit_sent    ),
    .ser_data_o       ( ser_data_o     ),
    .ser_valid_o      ( ser_valid_o    )
  );

  //////////////////////////////////////////////////
  // Receive side
  //////////////////////////////////////////////////

  serial_link_rx_path u_rx_path (
    .clk_i               ( clk_i             ),
    .rst_n_i             ( rst_n_i           ),
    .ser_data_i          ( ser_data_i        ),
    .ser_valid_i         ( ser_valid_i       ),
    .data_o              ( data_out_o        ),
    .valid_o             ( data_out_valid_o  ),
    .ready_i             ( data_out_ready_i  ),
    .credit_recv_o       ( credit_recv       ),
    .credit_recv_valid_o ( credit_recv_valid ),
    .credit_pending_o    ( credit_pending    ),
    .credit_sent_i       ( credit_sent       )
  );

endmodule

//--- serial_link_config.svh
// Serial link configuration
// Word width, lane count and credit depth, plus the frame sizes
// that follow from them
`ifndef SERIAL_LINK_CONFIG_SVH
`define SERIAL_LINK_CONFIG_SVH

// User word width
`define SL_DATA_WIDTH 32

// Serial data lanes, one bit each per beat
`define SL_NUM_LANES 4

// Receive FIFO depth and the credit count at reset
`define SL_NUM_CREDITS 4

// Holds 0 up to SL_NUM_CREDITS
`define SL_CREDIT_WIDTH 3

// Data, two tag bits and credits, rounded up to whole beats
`define SL_PAYLOAD_WIDTH \
  (((`SL_DATA_WIDTH + 2 + `SL_CREDIT_WIDTH + `SL_NUM_LANES - 1) / `SL_NUM_LANES) * `SL_NUM_LANES)

// Beats in one frame
`define SL_PAYLOAD_SPLITS (`SL_PAYLOAD_WIDTH / `SL_NUM_LANES)

`endif

//--- serial_link_framer.sv
// Serial link framer
// Picks a data or credit-only frame, packs tag, credits and word
// into a payload and shifts it out one lane beat per cycle
`timescale 1ns/1ps
`include "serial_link_config.svh"

module serial_link_framer
  import serial_link_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  data_t   word_i,
  input  logic    word_valid_i,
  output logic    word_take_o,
  input  credit_t credit_pending_i,
  output logic    credit_sent_o,
  output lane_t   ser_data_o,
  output logic    ser_valid_o
);

  localparam int LANES    = `SL_NUM_LANES;
  localparam int SPLITS   = `SL_PAYLOAD_SPLITS;
  localparam int TAG_LSB  = `SL_CREDIT_WIDTH;
  localparam int DATA_LSB = TAG_LSB + $bits(tag_e);

  typedef enum logic {
    FRM_IDLE,
    FRM_SEND
  } frm_state_e;

  frm_state_e state_q;
  beat_cnt_t  beat_cnt_q;
  payload_t   shift_q;
  payload_t   payload_d;
  logic       frm_idle;
  logic       take;
  logic       credit_only;
  logic       start;

  // Data frames win, credit-only frames go out when nothing else waits
  assign frm_idle    = (state_q == FRM_IDLE);
  assign take        = frm_idle && word_valid_i;
  assign credit_only = frm_idle && !word_valid_i && (credit_pending_i != '0);
  assign start       = take || credit_only;

  // Credits low, tag above, data on top, padding stays zero
  always_comb begin
    payload_d = '0;
    payload_d[TAG_LSB-1:0] = credit_pending_i;
    if (take) begin
      payload_d[DATA_LSB-1:TAG_LSB]       = TAG_DATA;
      payload_d[DATA_LSB +: `SL_DATA_WIDTH] = word_i;
    end else begin
      payload_d[DATA_LSB-1:TAG_LSB] = TAG_CREDIT;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= FRM_IDLE;
      beat_cnt_q <= '0;
    end else begin
      case (state_q)
        FRM_IDLE: begin
          if (start) begin
            state_q    <= FRM_SEND;
            beat_cnt_q <= '0;
          end
        end
        FRM_SEND: begin
          // Back to idle forces the gap between frames
          if (beat_cnt_q == beat_cnt_t'(SPLITS - 1)) begin
            state_q <= FRM_IDLE;
          end else begin
            beat_cnt_q <= beat_cnt_q + beat_cnt_t'(1);
          end
        end
        default: state_q <= FRM_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      shift_q <= payload_d;
    end else if (!frm_idle) begin
      shift_q <= {{LANES{1'b0}}, shift_q[`SL_PAYLOAD_WIDTH-1:LANES]};
    end
  end

  assign word_take_o   = take;
  assign credit_sent_o = start;
  assign ser_valid_o   = !frm_idle;
  assign ser_data_o    = frm_idle ? '0 : shift_q[LANES-1:0];

endmodule

//--- serial_link_pkg.sv
// Serial link shared types
// Vector types for words, beats, credits and frames, and the
// frame header tag
`include "serial_link_config.svh"

package serial_link_pkg;

  // One user word
  typedef logic [`SL_DATA_WIDTH-1:0] data_t;

  // One beat across all lanes
  typedef logic [`SL_NUM_LANES-1:0] lane_t;

  // Credit count
  typedef logic [`SL_CREDIT_WIDTH-1:0] credit_t;

  // Whole frame, padding included
  typedef logic [`SL_PAYLOAD_WIDTH-1:0] payload_t;

  // Beat index inside a frame
  typedef logic [$clog2(`SL_PAYLOAD_SPLITS)-1:0] beat_cnt_t;

  // Header tag, zero is left unused so an empty frame never decodes
  typedef enum logic [1:0] {
    TAG_DATA   = 2'd1,
    TAG_CREDIT = 2'd2
  } tag_e;

endpackage

//--- serial_link_rx_path.sv
// Serial link receive path
// Rebuilds frames from lane beats, stores data words in the receive
// FIFO, forwards the credit field of every frame and counts freed
// FIFO slots to be returned to the far end
`timescale 1ns/1ps
`include "serial_link_config.svh"

module serial_link_rx_path
  import serial_link_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  lane_t   ser_data_i,
  input  logic    ser_valid_i,
  output data_t   data_o,
  output logic    valid_o,
  input  logic    ready_i,
  output credit_t credit_recv_o,
  output logic    credit_recv_valid_o,
  output credit_t credit_pending_o,
  input  logic    credit_sent_i
);

  localparam int SPLITS   = `SL_PAYLOAD_SPLITS;
  localparam int DEPTH    = `SL_NUM_CREDITS;
  localparam int PTR_W    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int TAG_LSB  = `SL_CREDIT_WIDTH;
  localparam int DATA_LSB = TAG_LSB + $bits(tag_e);

  beat_cnt_t        beat_cnt_q;
  payload_t         payload_q;
  logic             frame_done_q;
  tag_e             frame_tag;
  logic             push;
  logic             pop;
  data_t            fifo_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  credit_t          fifo_cnt_q;
  credit_t          pending_q;
  credit_t          sent_amt;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + PTR_W'(1);
  endfunction

  //////////////////////////////////////////////////
  // Deserializer
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      beat_cnt_q   <= '0;
      frame_done_q <= 1'b0;
    end else begin
      frame_done_q <= 1'b0;
      if (ser_valid_i) begin
        if (beat_cnt_q == beat_cnt_t'(SPLITS - 1)) begin
          beat_cnt_q   <= '0;
          frame_done_q <= 1'b1;
        end else begin
          beat_cnt_q <= beat_cnt_q + beat_cnt_t'(1);
        end
      end
    end
  end

  // Beat 0 enters first and ends up in the lowest bits
  always_ff @(posedge clk_i) begin
    if (ser_valid_i) begin
      payload_q <= {ser_data_i, payload_q[`SL_PAYLOAD_WIDTH-1:`SL_NUM_LANES]};
    end
  end

  assign frame_tag           = tag_e'(payload_q[DATA_LSB-1:TAG_LSB]);
  assign credit_recv_o       = payload_q[TAG_LSB-1:0];
  assign credit_recv_valid_o = frame_done_q;

  //////////////////////////////////////////////////
  // Receive FIFO and return credits
  //////////////////////////////////////////////////

  // Credits at the far end keep this from overflowing
  assign push = frame_done_q && (frame_tag == TAG_DATA);
  assign pop  = valid_o && ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= payload_q[DATA_LSB +: `SL_DATA_WIDTH];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
      pending_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push, pop})
        2'b10:   fifo_cnt_q <= fifo_cnt_q + credit_t'(1);
        2'b01:   fifo_cnt_q <= fifo_cnt_q - credit_t'(1);
        default: fifo_cnt_q <= fifo_cnt_q;
      endcase
      // Framer latches the whole count in the cycle it pulses
      pending_q <= pending_q - sent_amt + (pop ? credit_t'(1) : credit_t'(0));
    end
  end

  assign sent_amt         = credit_sent_i ? pending_q : '0;
  assign credit_pending_o = pending_q;
  assign valid_o          = (fifo_cnt_q != '0);
  assign data_o           = fifo_mem[rd_ptr_q];

endmodule

//--- serial_link_tx_path.sv
// Serial link transmit path
// Accepts user words while far-end credits remain, parks one word
// until the framer picks it up, and tracks returned credits
`timescale 1ns/1ps
`include "serial_link_config.svh"

module serial_link_tx_path
  import serial_link_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  data_t   data_i,
  input  logic    valid_i,
  output logic    ready_o,
  input  credit_t credit_add_i,
  input  logic    credit_add_valid_i,
  output data_t   word_o,
  output logic    word_valid_o,
  input  logic    word_take_i
);

  credit_t credit_q;
  credit_t credit_d;
  credit_t credit_gain;
  data_t   word_q;
  logic    word_valid_q;
  logic    word_valid_d;
  logic    ready_q;
  logic    accept;

  assign accept      = valid_i && ready_q;
  assign credit_gain = credit_add_valid_i ? credit_add_i : '0;

  // Credits come back from the far end and are spent per word
  always_comb begin
    credit_d = credit_q + credit_gain;
    if (accept) begin
      credit_d = credit_d - credit_t'(1);
    end
  end

  assign word_valid_d = accept || (word_valid_q && !word_take_i);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_q     <= credit_t'(`SL_NUM_CREDITS);
      word_valid_q <= 1'b0;
      ready_q      <= 1'b1;
    end else begin
      credit_q     <= credit_d;
      word_valid_q <= word_valid_d;
      // Ready follows the next state, so a full slot is never offered
      ready_q      <= (credit_d != '0) && !word_valid_d;
    end
  end

  // Word slot
  always_ff @(posedge clk_i) begin
    if (accept) begin
      word_q <= data_i;
    end
  end

  assign ready_o      = ready_q;
  assign word_o       = word_q;
  assign word_valid_o = word_valid_q;

endmodule

//--- tb_serial_link.sv
// Serial link testbench
// Loops the serial lanes back into the DUT, drives random words and
// ready patterns, and checks word order, output stability, credit
// back-pressure and frame timing with concurrent assertions
`timescale 1ns/1ps
`include "serial_link_config.svh"

module tb_serial_link
  import serial_link_pkg::*;
();

  // Four phases need about 9000 cycles at most
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int HOLD_CYCLES    = 300;
  // Zero bits on top of the last beat
  localparam int PAD_BITS       = `SL_PAYLOAD_WIDTH - `SL_DATA_WIDTH - $bits(tag_e)
                                  - `SL_CREDIT_WIDTH;

  logic        clk;
  logic        rst_n;
  data_t       data_in;
  logic        data_in_valid;
  logic        data_in_ready;
  data_t       data_out;
  logic        data_out_valid;
  logic        data_out_ready;
  lane_t       ser_data;
  logic        ser_valid;
  logic        in_fire;
  logic        out_fire;

  data_t       sb_q [$];
  data_t       head_q      = '0;
  int          sb_cnt      = 0;
  logic        in_fired    = 1'b0;
  data_t       held_word   = '0;
  logic        held        = 1'b0;
  int          run_len     = 0;
  logic        hold_phase  = 1'b0;
  int          cycle_cnt   = 0;
  logic [31:0] rng;

  assign in_fire  = data_in_valid && data_in_ready;
  assign out_fire = data_out_valid && data_out_ready;

  // Serial output wired straight back to the serial input
  serial_link u_dut (
    .clk_i            ( clk            ),
    .rst_n_i          ( rst_n          ),
    .data_in_i        ( data_in        ),
    .data_in_valid_i  ( data_in_valid  ),
    .data_in_ready_o  ( data_in_ready  ),
    .data_out_o       ( data_out       ),
    .data_out_valid_o ( data_out_valid ),
    .data_out_ready_i ( data_out_ready ),
    .ser_data_o       ( ser_data       ),
    .ser_valid_o      ( ser_valid      ),
    .ser_data_i       ( ser_data       ),
    .ser_valid_i      ( ser_valid      )
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic stop_with_failure();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic fail_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    $display("ERROR %s expected 0x%0h actual 0x%0h", name, exp, act);
    stop_with_failure();
  endtask

  task automatic fail_text(input string msg);
    $display("%s", msg);
    stop_with_failure();
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  //////////////////////////////////////////////////
  // Scoreboard and monitors
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    in_fired = in_fire;
    if (in_fire) sb_q.push_back(data_in);
    if (out_fire && sb_q.size() > 0) void'(sb_q.pop_front());
    head_q    = (sb_q.size() > 0) ? sb_q[0] : '0;
    sb_cnt    = sb_q.size();
    held_word = data_out;
    held      = rst_n && data_out_valid && !data_out_ready;
    // Length of the current high run on the lanes
    run_len   = (!rst_n || !ser_valid) ? 0 : run_len + 1;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      fail_text($sformatf("Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // State right after reset
  assert property (@(posedge clk) $rose(rst_n) |-> !ser_valid)
    else fail_value("ser_valid_o", 0, $sampled(ser_valid));
  assert property (@(posedge clk) $rose(rst_n) |-> !data_out_valid)
    else fail_value("data_out_valid_o", 0, $sampled(data_out_valid));
  assert property (@(posedge clk) $rose(rst_n) |-> data_in_ready)
    else fail_value("data_in_ready_o", 1, $sampled(data_in_ready));

  // Output words match accepted words in order
  assert property (@(posedge clk) disable iff (!rst_n) out_fire |-> sb_cnt != 0)
    else fail_text("Output transfer with no accepted word outstanding");
  assert property (@(posedge clk) disable iff (!rst_n)
                   out_fire && sb_cnt != 0 |-> data_out == head_q)
    else fail_value("data_out_o", $sampled(head_q), $sampled(data_out));

  // Valid holds with stable data until the word transfers
  assert property (@(posedge clk) disable iff (!rst_n) held |-> data_out_valid)
    else fail_value("data_out_valid_o", 1, $sampled(data_out_valid));
  assert property (@(posedge clk) disable iff (!rst_n) held |-> data_out == held_word)
    else fail_value("data_out_o", $sampled(held_word), $sampled(data_out));

  // Frames are exactly SL_PAYLOAD_SPLITS beats with a gap after
  assert property (@(posedge clk) disable iff (!rst_n)
                   ser_valid |-> run_len < `SL_PAYLOAD_SPLITS)
    else fail_text("Frame on ser_valid_o ran past its last beat without a gap");
  assert property (@(posedge clk) disable iff (!rst_n)
                   !ser_valid && run_len != 0 |-> run_len == `SL_PAYLOAD_SPLITS)
    else fail_value("ser_valid_o frame length", `SL_PAYLOAD_SPLITS, $sampled(run_len));

  // Padding at the top of the last beat goes out as zero
  assert property (@(posedge clk) disable iff (!rst_n)
                   ser_valid && run_len == `SL_PAYLOAD_SPLITS - 1
                   |-> ser_data[`SL_NUM_LANES-1 -: PAD_BITS] == '0)
    else fail_value("ser_data_o", 0, $sampled(ser_data));

  // Back-pressure hold with the receive FIFO full
  assert property (@(posedge clk) disable iff (!rst_n) hold_phase |-> !data_in_ready)
    else fail_value("data_in_ready_o", 0, $sampled(data_in_ready));
  assert property (@(posedge clk) disable iff (!rst_n)
                   hold_phase |-> sb_cnt == `SL_NUM_CREDITS)
    else fail_value("accepted word count", `SL_NUM_CREDITS, $sampled(sb_cnt));
  assert property (@(posedge clk) disable iff (!rst_n) hold_phase |-> data_out_valid)
    else fail_value("data_out_valid_o", 1, $sampled(data_out_valid));

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic stream_words(input int count, input bit gaps, input bit random_ready);
    int   left;
    logic pending;
    left    = count;
    pending = 1'b0;
    while (left > 0 || pending) begin
      @(negedge clk);
      if (pending && in_fired) pending = 1'b0;
      if (!pending && left > 0) begin
        rng = xorshift32(rng);
        if (!gaps || rng[0]) begin
          rng     = xorshift32(rng);
          data_in = rng;
          pending = 1'b1;
          left--;
        end
      end
      data_in_valid = pending;
      if (random_ready) begin
        rng            = xorshift32(rng);
        data_out_ready = rng[1];
      end else begin
        data_out_ready = 1'b1;
      end
    end
  endtask

  task automatic drain_output(input bit random_ready);
    while (sb_cnt != 0) begin
      @(negedge clk);
      rng            = xorshift32(rng);
      data_out_ready = random_ready ? rng[1] : 1'b1;
    end
  endtask

  initial begin
    rst_n          = 1'b0;
    data_in        = '0;
    data_in_valid  = 1'b0;
    data_out_ready = 1'b0;
    rng            = 32'h845e;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    // Random gaps with the output always ready
    stream_words(40, 1'b1, 1'b0);
    drain_output(1'b0);

    // Fill the far end with the output stalled
    @(negedge clk);
    data_out_ready = 1'b0;
    rng            = xorshift32(rng);
    data_in        = rng;
    data_in_valid  = 1'b1;
    while (sb_cnt < `SL_NUM_CREDITS || !data_out_valid) begin
      @(negedge clk);
      if (in_fired) begin
        rng     = xorshift32(rng);
        data_in = rng;
      end
    end
    hold_phase = 1'b1;
    repeat (HOLD_CYCLES) @(negedge clk);
    hold_phase    = 1'b0;
    data_in_valid = 1'b0;

    // More words after the drain need credits back from credit-only frames
    drain_output(1'b0);
    stream_words(12, 1'b0, 1'b0);
    drain_output(1'b0);

    // Random valid and random ready together
    stream_words(200, 1'b1, 1'b1);
    drain_output(1'b1);

    repeat (20) @(negedge clk);
    $display("All checks passed");
    $finish;
  end

endmodule
